/* sim/hilbertStim.txt */
# start stop valid result sample expectedRe expectedIm
# result 1 means a pair is due three edges after the strobe. A start holds the strobe over the load.
0 0 1 0 777 0 0
1 0 1 0 555 0 0
0 0 1 1 1000 0 -1490000
0 0 1 1 0 0 0
0 0 1 1 0 0 -2086000
0 0 1 1 0 0 0
0 0 1 1 0 0 -3477000
0 0 1 1 0 0 0
0 0 1 1 0 0 -10430000
0 0 1 1 0 16384000 0
0 0 1 1 0 0 10430000
0 0 1 1 0 0 0
0 0 1 1 0 0 3477000
0 0 1 1 0 0 0
0 0 1 1 0 0 2086000
0 0 1 1 0 0 0
0 0 1 1 0 0 1490000
0 0 1 1 2000 0 -2980000
0 0 0 0 0 0 0
0 0 1 1 -3000 0 4470000
0 0 1 1 500 0 -4917000
0 0 0 0 0 0 0
0 0 1 1 4000 0 298000
0 1 0 0 0 0 0
0 0 1 0 1234 0 0
1 0 0 0 0 0 0
0 0 1 1 1000 0 -1490000
0 0 1 1 0 0 0
0 0 1 1 -2000 0 894000

/* hilbertTransform.f */
+incdir+src
src/hilbertPkg.sv
src/hilbertControl.sv
src/hilbertCoeffLoader.sv
src/firFilter.sv
src/analyticAlign.sv
src/hilbertTransform.sv
sim/hilbertClockGen.sv
sim/hilbertTransformTb.sv

/* sim/hilbertTransformTb.sv */
`timescale 1ns/1ns
`include "hilbertTransform_macros.svh"

module hilbertTransformTb;

	localparam int dataWidth = `HILBERT_DATA_WIDTH;
	localparam int wideWidth = 2 * dataWidth;
	localparam int loadStrobes = 4;
	localparam int runWaitLimit = `HILBERT_LENGTH + 10;

	// One line of the stim file.
	typedef struct packed {
		logic start;
		logic stop;
		logic valid;
		logic hasResult;
		logic signed [dataWidth-1:0] sample;
		logic signed [wideWidth-1:0] re;
		logic signed [wideWidth-1:0] im;
	} stimStep;

	// A pair that the DUT owes on a given edge.
	typedef struct packed {
		logic [31:0] due;
		logic signed [wideWidth-1:0] re;
		logic signed [wideWidth-1:0] im;
	} dueBeat;

	logic clock;
	logic arstN;
	logic start;
	logic stop;
	logic sampleValid;
	logic signed [dataWidth-1:0] sample;
	logic running;
	hilbertPkg::analyticBeat result;

	stimStep steps [$];
	dueBeat pending [$];
	dueBeat arrived;
	logic phase;
	int edgeCount = 0;
	int stepLimit = 0;
	int mismatchCount = 0;
	int failureCount = 0;
	int checkedCount = 0;

	hilbertClockGen u_hilbertClockGen (
		.clock (clock),
		.arstN (arstN)
	);

	hilbertTransform u_hilbertTransform (
		.clock       (clock),
		.arstN       (arstN),
		.start       (start),
		.stop        (stop),
		.sampleValid (sampleValid),
		.sample      (sample),
		.running     (running),
		.result      (result)
	);

	// Counts rising edges. A process woken by the same edge still reads the previous count.
	always @(posedge clock) edgeCount <= edgeCount + 1;

	task automatic checkValue(input logic signed [63:0] actual,
			input logic signed [63:0] expected, input string what);
		if (actual !== expected) begin
			mismatchCount++;
			$display("Mismatch at %0t ns: %s is %0d, expected %0d",
				$time, what, actual, expected);
		end
	endtask

	// Reads every data line of the stim file. Lines that do not hold seven numbers are notes.
	task automatic loadStim();
		int fd;
		int fields;
		int startCount;
		int colStart;
		int colStop;
		int colValid;
		int colResult;
		int colSample;
		int colRe;
		int colIm;
		logic [8*160-1:0] lineText;
		stimStep entry;
		startCount = 0;
		fd = $fopen("sim/hilbertStim.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/hilbertStim.txt for reading");
			$display("Result: FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				lineText = '0;
				if ($fgets(lineText, fd) != 0) begin
					fields = $sscanf(lineText, "%d %d %d %d %d %d %d", colStart, colStop,
						colValid, colResult, colSample, colRe, colIm);
					if (fields == 7) begin
						entry.start = colStart[0];
						entry.stop = colStop[0];
						entry.valid = colValid[0];
						entry.hasResult = colResult[0];
						entry.sample = colSample[dataWidth-1:0];
						entry.re = colRe;
						entry.im = colIm;
						steps.push_back(entry);
						startCount += colStart;
					end
				end
			end
			$fclose(fd);
			// Each start costs a full coefficient load plus the strobes sent during it.
			stepLimit = steps.size() + startCount * (`HILBERT_LENGTH + 8) + 40;
		end
	endtask

	// Waits on falling edges until running reaches the wanted level.
	task automatic waitRunning(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (running !== level && cycles < runWaitLimit);
		if (running !== level) begin
			failureCount++;
			$display("running did not go to %0b within %0d cycles at %0t ns",
				level, runWaitLimit, $time);
		end
	endtask

	// Drives one stim line on one rising edge.
	task automatic runStep(input stimStep s);
		dueBeat entry;
		@(negedge clock);
		checkValue(running, phase, "running level");
		@(posedge clock);
		start <= s.start;
		stop <= s.stop;
		sampleValid <= s.valid;
		sample <= s.sample;
		// This edge still reads the old count, so the pair is due three edges from now.
		if (s.hasResult) begin
			entry.due = edgeCount + 4;
			entry.re = s.re;
			entry.im = s.im;
			pending.push_back(entry);
		end
		// The load lasts LENGTH+1 edges, so the held strobe falls entirely inside it.
		if (s.start) begin
			@(posedge clock);
			start <= 1'b0;
			repeat (loadStrobes - 1) @(posedge clock);
			sampleValid <= 1'b0;
			waitRunning(1'b1);
			phase = 1'b1;
		end
		if (s.stop) begin
			waitRunning(1'b0);
			phase = 1'b0;
		end
	endtask

	initial begin
		start <= 1'b0;
		stop <= 1'b0;
		sampleValid <= 1'b0;
		sample <= '0;
		phase = 1'b0;
		loadStim();
		@(posedge arstN);
		@(negedge clock);
		checkValue(running, 1'b0, "running after reset");
		checkValue(result.valid, 1'b0, "result valid after reset");
		for (int i = 0; i < steps.size(); i++) begin
			runStep(steps[i]);
		end
		@(posedge clock);
		start <= 1'b0;
		stop <= 1'b0;
		sampleValid <= 1'b0;
		sample <= '0;
		while (pending.size() != 0) @(negedge clock);
		// A short quiet window catches any stray pair after the last one.
		repeat (4) @(negedge clock);
		$display("Checked %0d results with %0d mismatches and %0d other errors",
			checkedCount, mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Every valid pair must match the oldest owed pair, and it must come on its due edge.
	always @(negedge clock) begin
		if (arstN === 1'b1) begin
			if (result.valid === 1'b1) begin
				if (pending.size() == 0 || pending[0].due != edgeCount) begin
					failureCount++;
					$display("Unexpected result at %0t ns with no sample due on this edge", $time);
				end else begin
					arrived = pending.pop_front();
					checkValue(result.re, arrived.re, "real part");
					checkValue(result.im, arrived.im, "imaginary part");
					checkedCount++;
				end
			end else if (pending.size() != 0 && pending[0].due == edgeCount) begin
				failureCount++;
				arrived = pending.pop_front();
				$display("No result at %0t ns although a sample was due on this edge", $time);
			end
		end
	end

	initial begin
		wait (stepLimit > 0);
		repeat (stepLimit) @(posedge clock);
		$display("Watchdog expired after %0d clock cycles before the test finished", stepLimit);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* sim/hilbertClockGen.sv */
`timescale 1ns/1ns

module hilbertClockGen (
	output logic clock,
	output logic arstN
);

	localparam int halfPeriod = 20;
	localparam int resetCycles = 5;

	// Free-running clock with a 40 ns period.
	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	// Reset stays low for the first cycles and is released on a falling edge.
	// That keeps the release well away from the edge that the DUT samples on.
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
	end

endmodule

/* src/hilbertTransform.sv */
`timescale 1ns/1ns
`include "hilbertTransform_macros.svh"

module hilbertTransform (
	input  logic                                  clock,
	input  logic                                  arstN,
	input  logic                                  start,
	input  logic                                  stop,
	input  logic                                  sampleValid,
	input  logic signed [`HILBERT_DATA_WIDTH-1:0] sample,
	output logic                                  running,
	output hilbertPkg::analyticBeat               result
);

	logic                    loadStart;
	logic                    flush;
	hilbertPkg::sampleBeat   sampleIn;
	hilbertPkg::coeffBeat    coeffIn;
	hilbertPkg::analyticBeat firOut;

	// Sequencer and sample capture.
	hilbertControl u_hilbertControl (
		.clock       (clock),
		.arstN       (arstN),
		.start       (start),
		.stop        (stop),
		.sampleValid (sampleValid),
		.sample      (sample),
		.coeffIn     (coeffIn),
		.loadStart   (loadStart),
		.flush       (flush),
		.sampleIn    (sampleIn),
		.running     (running)
	);

	// Serial source of the kernel.
	hilbertCoeffLoader u_hilbertCoeffLoader (
		.clock     (clock),
		.arstN     (arstN),
		.loadStart (loadStart),
		.coeffIn   (coeffIn)
	);

	// Imaginary path.
	firFilter u_firFilter (
		.clock    (clock),
		.arstN    (arstN),
		.coeffIn  (coeffIn),
		.sampleIn (sampleIn),
		.flush    (flush),
		.firOut   (firOut)
	);

	// Real path and output pairing.
	analyticAlign u_analyticAlign (
		.clock    (clock),
		.arstN    (arstN),
		.sampleIn (sampleIn),
		.firOut   (firOut),
		.flush    (flush),
		.result   (result)
	);

endmodule

/* src/analyticAlign.sv */
`timescale 1ns/1ns
`include "hilbertTransform_macros.svh"

module analyticAlign (
	input  logic                    clock,
	input  logic                    arstN,
	input  hilbertPkg::sampleBeat   sampleIn,
	input  hilbertPkg::analyticBeat firOut,
	input  logic                    flush,
	output hilbertPkg::analyticBeat result
);

	localparam int tapCount = `HILBERT_LENGTH;
	localparam int dataWidth = `HILBERT_DATA_WIDTH;
	localparam int sumWidth = 2 * dataWidth;
	localparam int delayDepth = (tapCount - 1) / 2;

	// The real path matches the group delay of the kernel, which is its centre tap.
	logic signed [dataWidth-1:0] delayLine [delayDepth];
	logic signed [sumWidth-1:0]  delayedWide;
	logic signed [sumWidth-1:0]  realStage;

	// Sign extension to the product width.
	assign delayedWide = delayLine[delayDepth-1];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < delayDepth; i++) begin
				delayLine[i] <= '0;
			end
			realStage <= '0;
			result    <= '0;
		end else begin
			// This stage lines up with the FIR sum register.
			// The shift puts the real part on the coefficient scale.
			if (sampleIn.valid) begin
				realStage <= delayedWide <<< `HILBERT_COEFF_SHIFT;
			end

			if (flush) begin
				for (int i = 0; i < delayDepth; i++) begin
					delayLine[i] <= '0;
				end
			end else if (sampleIn.valid) begin
				delayLine[0] <= sampleIn.data;
				for (int i = 1; i < delayDepth; i++) begin
					delayLine[i] <= delayLine[i-1];
				end
			end

			// Both halves leave together.
			result.valid <= firOut.valid;
			if (firOut.valid) begin
				result.re <= realStage;
				result.im <= firOut.im;
			end
		end
	end

endmodule

/* src/firFilter.sv */
`timescale 1ns/1ns
`include "hilbertTransform_macros.svh"

module firFilter (
	input  logic                    clock,
	input  logic                    arstN,
	input  hilbertPkg::coeffBeat    coeffIn,
	input  hilbertPkg::sampleBeat   sampleIn,
	input  logic                    flush,
	output hilbertPkg::analyticBeat firOut
);

	localparam int tapCount = `HILBERT_LENGTH;
	localparam int dataWidth = `HILBERT_DATA_WIDTH;
	localparam int sumWidth = 2 * dataWidth;

	// Tap i weights the sample that arrived i samples ago.
	logic signed [dataWidth-1:0] taps [tapCount];

	// Previous samples, with the most recent at index 0.
	// The newest sample comes straight from the input.
	logic signed [dataWidth-1:0] history [tapCount-1];

	logic signed [sumWidth-1:0] productSum;

	// Coefficients enter at the top and walk down.
	// After a full load the first coefficient sits in tap 0.
	always_ff @(posedge clock) begin
		if (coeffIn.valid) begin
			for (int i = 0; i < tapCount - 1; i++) begin
				taps[i] <= taps[i + 1];
			end
			taps[tapCount-1] <= coeffIn.coeff;
		end
	end

	// Full multiply-accumulate over the new sample and the stored history.
	// The sum fits the product width for this kernel size.
	always_comb begin
		productSum = taps[0] * sampleIn.data;
		for (int i = 1; i < tapCount; i++) begin
			productSum = productSum + taps[i] * history[i-1];
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < tapCount - 1; i++) begin
				history[i] <= '0;
			end
			firOut <= '0;
		end else begin
			firOut.valid <= sampleIn.valid;
			if (sampleIn.valid) begin
				firOut.im <= productSum;
			end

			// A flush clears only the history.
			// The kernel stays loaded for a later restart.
			if (flush) begin
				for (int i = 0; i < tapCount - 1; i++) begin
					history[i] <= '0;
				end
			end else if (sampleIn.valid) begin
				history[0] <= sampleIn.data;
				for (int i = 1; i < tapCount - 1; i++) begin
					history[i] <= history[i-1];
				end
			end
		end
	end

endmodule

/* src/hilbertCoeffLoader.sv */
`timescale 1ns/1ns
`include "hilbertTransform_macros.svh"

module hilbertCoeffLoader (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 loadStart,
	output hilbertPkg::coeffBeat coeffIn
);

	localparam int tapCount = `HILBERT_LENGTH;
	localparam int dataWidth = `HILBERT_DATA_WIDTH;
	localparam int centreTap = (tapCount - 1) / 2;
	localparam int indexWidth = $clog2(tapCount);
	localparam logic [indexWidth-1:0] lastIndex = indexWidth'(tapCount - 1);
	localparam real piValue = 3.14159265358979323846;

	// Ideal Hilbert kernel, 2/(pi*k) for odd offsets k and zero for even ones.
	// The result is rounded half away from zero at the coefficient scale.
	function automatic logic signed [dataWidth-1:0] coeffValue(input int tap);
		int offset;
		int roundedInt;
		real scaled;
		offset = tap - centreTap;
		roundedInt = 0;
		if (offset % 2 != 0) begin
			scaled = 2.0 * (2.0 ** `HILBERT_COEFF_SHIFT) / (piValue * offset);
			if (scaled >= 0.0) begin
				roundedInt = $rtoi(scaled + 0.5);
			end else begin
				roundedInt = -$rtoi(0.5 - scaled);
			end
		end
		return roundedInt[dataWidth-1:0];
	endfunction

	logic signed [dataWidth-1:0] coeffTable [tapCount];
	logic                        active;
	logic [indexWidth-1:0]       index;

	// The table is fixed at elaboration.
	for (genvar tap = 0; tap < tapCount; tap++) begin : genTable
		assign coeffTable[tap] = coeffValue(tap);
	end

	// One beat per cycle while the index walks the table.
	always_comb begin
		coeffIn.valid = active;
		coeffIn.last  = active && (index == lastIndex);
		coeffIn.coeff = active ? coeffTable[index] : '0;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			active <= 1'b0;
			index  <= '0;
		end else if (loadStart) begin
			active <= 1'b1;
			index  <= '0;
		end else if (active) begin
			if (index == lastIndex) begin
				active <= 1'b0;
				index  <= '0;
			end else begin
				index <= index + 1'b1;
			end
		end
	end

endmodule

/* src/hilbertControl.sv */
`timescale 1ns/1ns
`include "hilbertTransform_macros.svh"

module hilbertControl (
	input  logic                                  clock,
	input  logic                                  arstN,
	input  logic                                  start,
	input  logic                                  stop,
	input  logic                                  sampleValid,
	input  logic signed [`HILBERT_DATA_WIDTH-1:0] sample,
	input  hilbertPkg::coeffBeat                  coeffIn,
	output logic                                  loadStart,
	output logic                                  flush,
	output hilbertPkg::sampleBeat                 sampleIn,
	output logic                                  running
);

	hilbertPkg::hilbertState state;

	// The design only takes samples in the run state.
	assign running = (state == hilbertPkg::stRun);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state     <= hilbertPkg::stIdle;
			loadStart <= 1'b0;
			flush     <= 1'b0;
			sampleIn  <= '0;
		end else begin
			// Pulses and the sample strobe default low every cycle.
			loadStart      <= 1'b0;
			flush          <= 1'b0;
			sampleIn.valid <= 1'b0;

			case (state)
				// Wait for the start level.
				// The loader is kicked off with a single pulse.
				hilbertPkg::stIdle: begin
					if (start) begin
						state     <= hilbertPkg::stLoadCoeff;
						loadStart <= 1'b1;
					end
				end

				// The loader flags its final beat.
				// That beat reaches the FIR on this same edge, so run can begin.
				hilbertPkg::stLoadCoeff: begin
					if (coeffIn.valid && coeffIn.last) begin
						state <= hilbertPkg::stRun;
					end
				end

				// A stop wins over a sample arriving on the same edge.
				// That keeps the flush from colliding with a live sample downstream.
				hilbertPkg::stRun: begin
					if (stop) begin
						state <= hilbertPkg::stFlush;
						flush <= 1'b1;
					end else if (sampleValid) begin
						sampleIn.valid <= 1'b1;
						sampleIn.data  <= sample;
					end
				end

				// The flush pulse is out during this state.
				// Samples still in the pipeline drain normally.
				hilbertPkg::stFlush: begin
					state <= hilbertPkg::stIdle;
				end

				default: begin
					state <= hilbertPkg::stIdle;
				end
			endcase
		end
	end

endmodule

/* src/hilbertPkg.sv */
`include "hilbertTransform_macros.svh"

package hilbertPkg;

	// Sequencer states.
	// Load streams the kernel into the FIR, and flush clears the sample history.
	typedef enum logic [1:0] {
		stIdle,
		stLoadCoeff,
		stRun,
		stFlush
	} hilbertState;

	// One captured input sample and its strobe.
	typedef struct packed {
		logic valid;
		logic signed [`HILBERT_DATA_WIDTH-1:0] data;
	} sampleBeat;

	// One coefficient of the serial load stream.
	// The last bit marks the final tap of the kernel.
	typedef struct packed {
		logic valid;
		logic last;
		logic signed [`HILBERT_DATA_WIDTH-1:0] coeff;
	} coeffBeat;

	// Analytic output pair.
	// Both parts carry the full product width of the FIR.
	typedef struct packed {
		logic valid;
		logic signed [2*`HILBERT_DATA_WIDTH-1:0] re;
		logic signed [2*`HILBERT_DATA_WIDTH-1:0] im;
	} analyticBeat;

endpackage

/* src/hilbertTransform_macros.svh */
`ifndef HILBERT_TRANSFORM_MACROS_SVH
`define HILBERT_TRANSFORM_MACROS_SVH

// Number of FIR taps in the Hilbert kernel.
// The kernel is antisymmetric around its centre tap, so this must be odd.
`define HILBERT_LENGTH 15

// Width of an input sample and of one quantized coefficient.
`define HILBERT_DATA_WIDTH 16

// Fixed-point scale of the coefficients.
// Two bits are kept back for the sign and for the 2/pi peak of the kernel.
`define HILBERT_COEFF_SHIFT (`HILBERT_DATA_WIDTH - 2)

`endif
